// File: hw/peri_consts.svh
// Peripheral fabric constants
// Bus widths, slot assignments and GPIO register offsets

`ifndef PERI_CONSTS_SVH
`define PERI_CONSTS_SVH

// Core bus widths
`define PERI_ADDR_W 11
`define PERI_DATA_W 32

// Output pins and slots per bank
`define PERI_PINS   8
`define PERI_SLOTS  16

// Word bank slot assignments
`define PERI_SLOT_GPIO   1
`define PERI_SLOT_WORD_A 4
`define PERI_SLOT_WORD_B 5

// Byte bank slot assignments
`define PERI_SLOT_BYTE_A 0
`define PERI_SLOT_BYTE_B 1

// GPIO register offsets inside its 64 byte window
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN  6'h04
// Pin selects occupy 0x20 to 0x3C, one word per pin
`define GPIO_OFS_SEL 6'h20

// Every pin starts out driven by the GPIO output register
`define PERI_SEL_RESET 5'h01

`endif

// File: hw/peri_pkg.sv
// Peripheral fabric types
// Access size codes and the per-pin output function select

package peri_pkg;

    // Size code as driven by the core, all ones means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } peri_size_t;

    // Output function select for one pin
    typedef struct packed {
        logic       bank;   // 1 selects the byte bank
        logic [3:0] slot;
    } pin_sel_t;

endpackage

// File: hw/byte_peri.sv
// Byte interface example peripheral
// One read/write register driving the pins and an inverted input readback

`timescale 1ns/10ps

module byte_peri (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] i_ui_in,
    input  logic [3:0] i_addr_lo,
    input  logic       i_write,
    input  logic [7:0] i_data,
    output logic [7:0] o_rdata,
    output logic [7:0] o_pins
);

    logic [7:0] reg_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_q <= '0;
        end else if (i_write && i_addr_lo == 4'h0) begin
            reg_q <= i_data;
        end
    end

    always_comb begin
        case (i_addr_lo)
            4'h0:    o_rdata = reg_q;
            4'h1:    o_rdata = ~i_ui_in;
            default: o_rdata = '0;
        endcase
    end

    assign o_pins = reg_q;

endmodule

// File: hw/word_peri.sv
// Word interface example peripheral
// Size-aware data register that drives the pins, an interrupt flag
// set by data writes, and a read response one cycle after the request

`timescale 1ns/10ps

`include "peri_consts.svh"

module word_peri
    import peri_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`PERI_PINS-1:0]   i_ui_in,
    input  logic [5:0]              i_addr_lo,
    input  logic [`PERI_DATA_W-1:0] i_data,
    input  peri_size_t              i_write_n,
    input  peri_size_t              i_read_n,
    output logic [`PERI_DATA_W-1:0] o_rdata,
    output logic                    o_ready,
    output logic [`PERI_PINS-1:0]   o_pins,
    output logic                    o_interrupt
);

    localparam logic [5:0] OFS_DATA = 6'h00;
    localparam logic [5:0] OFS_IRQ  = 6'h04;

    logic [`PERI_DATA_W-1:0] data_q;
    logic                    irq_q;
    logic                    ready_q;
    logic [`PERI_DATA_W-1:0] rdata_q;
    logic                    read_en;

    assign read_en = (i_read_n != SIZE_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
            irq_q  <= 1'b0;
        end else if (i_write_n != SIZE_NONE) begin
            if (i_addr_lo == OFS_DATA) begin
                // Only the bytes covered by the access size change
                case (i_write_n)
                    SIZE_BYTE: data_q[7:0]  <= i_data[7:0];
                    SIZE_HALF: data_q[15:0] <= i_data[15:0];
                    default:   data_q       <= i_data;
                endcase
                irq_q <= 1'b1;
            end else if (i_addr_lo == OFS_IRQ && i_data[0]) begin
                irq_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= read_en;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en) begin
            case (i_addr_lo)
                OFS_DATA: rdata_q <= data_q;
                OFS_IRQ:  rdata_q <= {31'h0, irq_q};
                default:  rdata_q <= '0;
            endcase
        end
    end

    assign o_rdata     = rdata_q;
    assign o_ready     = ready_q;
    assign o_pins      = data_q[`PERI_PINS-1:0];
    assign o_interrupt = irq_q;

endmodule

// File: hw/gpio_ctrl.sv
// GPIO block
// Output register, input readback and one function select per output pin,
// which routes each pin from the chosen word or byte slot

`timescale 1ns/10ps

`include "peri_consts.svh"

module gpio_ctrl
    import peri_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [5:0]                            i_addr_lo,
    input  logic [`PERI_DATA_W-1:0]               i_data,
    input  peri_size_t                            i_write_n,
    input  peri_size_t                            i_read_n,
    input  logic [`PERI_PINS-1:0]                 i_ui_in,
    input  logic [`PERI_SLOTS-1:0][`PERI_PINS-1:0] i_user_pins,
    input  logic [`PERI_SLOTS-1:0][`PERI_PINS-1:0] i_simple_pins,
    output logic [`PERI_DATA_W-1:0]               o_rdata,
    output logic [`PERI_PINS-1:0]                 o_uo_out
);

    logic                                   wr_en;
    logic                                   sel_hit;
    logic [`PERI_PINS-1:0]                  gpio_out;
    pin_sel_t [`PERI_PINS-1:0]              sel_q;
    logic [`PERI_SLOTS-1:0][`PERI_PINS-1:0] user_pins;

    assign wr_en = (i_write_n != SIZE_NONE);

    // Any word aligned offset in the upper half of the window
    assign sel_hit = ({i_addr_lo[5], 3'b000, i_addr_lo[1:0]} == `GPIO_OFS_SEL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && i_addr_lo == `GPIO_OFS_OUT) begin
            gpio_out <= i_data[`PERI_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERI_PINS; i++) begin
                sel_q[i] <= pin_sel_t'(`PERI_SEL_RESET);
            end
        end else if (wr_en && sel_hit) begin
            sel_q[i_addr_lo[4:2]] <= pin_sel_t'(i_data[4:0]);
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_read_n != SIZE_NONE) begin
            if (i_addr_lo == `GPIO_OFS_OUT) begin
                o_rdata = {24'h0, gpio_out};
            end else if (i_addr_lo == `GPIO_OFS_IN) begin
                o_rdata = {24'h0, i_ui_in};
            end else if (sel_hit) begin
                o_rdata = {27'h0, sel_q[i_addr_lo[4:2]]};
            end
        end
    end

    // The GPIO slot drives its pins from the output register
    always_comb begin
        user_pins                  = i_user_pins;
        user_pins[`PERI_SLOT_GPIO] = gpio_out;
    end

    always_comb begin
        for (int i = 0; i < `PERI_PINS; i++) begin
            if (sel_q[i].bank) begin
                o_uo_out[i] = i_simple_pins[sel_q[i].slot][i];
            end else begin
                o_uo_out[i] = user_pins[sel_q[i].slot][i];
            end
        end
    end

endmodule

// File: hw/peri_bus_ctrl.sv
// Peripheral bus control
// Decodes the core address into a word or byte slot, gates the strobes
// per slot and registers the read data until the core completes the read

`timescale 1ns/10ps

`include "peri_consts.svh"

module peri_bus_ctrl
    import peri_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`PERI_ADDR_W-1:0]                 i_addr,
    input  peri_size_t                              i_data_write_n,
    input  peri_size_t                              i_data_read_n,
    input  logic                                    i_data_read_complete,
    input  logic [`PERI_SLOTS-1:0][`PERI_DATA_W-1:0] i_user_rdata,
    input  logic [`PERI_SLOTS-1:0]                  i_user_ready,
    input  logic [`PERI_SLOTS-1:0][7:0]             i_simple_rdata,
    output peri_size_t [`PERI_SLOTS-1:0]            o_user_write_n,
    output peri_size_t [`PERI_SLOTS-1:0]            o_user_read_n,
    output logic [`PERI_SLOTS-1:0]                  o_simple_write,
    output logic [`PERI_DATA_W-1:0]                 o_data,
    output logic                                    o_data_ready
);

    logic                    byte_bank;
    logic [3:0]              slot_idx;
    logic                    read_req;
    logic                    write_req;
    peri_size_t              read_n_gated;
    logic [`PERI_DATA_W-1:0] peri_rdata;
    logic                    peri_ready;
    logic                    capture;

    logic                    hold_q;
    logic                    ready_q;
    logic [`PERI_DATA_W-1:0] data_q;

    // Address bit 10 picks the byte bank
    assign byte_bank = i_addr[10];
    assign slot_idx  = byte_bank ? i_addr[7:4] : i_addr[9:6];

    assign read_req  = (i_data_read_n != SIZE_NONE);
    assign write_req = (i_data_write_n != SIZE_NONE);

    // No second read reaches a peripheral while its result is presented
    assign read_n_gated = ready_q ? SIZE_NONE : i_data_read_n;

    always_comb begin
        for (int s = 0; s < `PERI_SLOTS; s++) begin
            if (!byte_bank && slot_idx == 4'(s)) begin
                o_user_write_n[s] = i_data_write_n;
                o_user_read_n[s]  = read_n_gated;
            end else begin
                o_user_write_n[s] = SIZE_NONE;
                o_user_read_n[s]  = SIZE_NONE;
            end
            o_simple_write[s] = byte_bank && (slot_idx == 4'(s)) && write_req;
        end
    end

    // Byte slots answer at once and are zero extended
    always_comb begin
        if (byte_bank) begin
            peri_rdata = {24'h0, i_simple_rdata[slot_idx]};
            peri_ready = 1'b1;
        end else begin
            peri_rdata = i_user_rdata[slot_idx];
            peri_ready = i_user_ready[slot_idx];
        end
    end

    assign capture = !hold_q && peri_ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            // A new capture wins over a clear in the same cycle
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= peri_rdata;
        end
    end

    assign o_data = data_q;

    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_q || write_req;

endmodule

// File: hw/peri_fabric_top.sv
// Peripheral fabric top level
// Connects the bus control, GPIO and the example peripherals
// to the word and byte slot arrays; unpopulated slots are tied off

`timescale 1ns/10ps

`include "peri_consts.svh"

module peri_fabric_top
    import peri_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`PERI_PINS-1:0]   i_ui_in,
    input  logic [`PERI_ADDR_W-1:0] i_addr,
    input  logic [`PERI_DATA_W-1:0] i_data,
    input  peri_size_t              i_data_write_n,
    input  peri_size_t              i_data_read_n,
    input  logic                    i_data_read_complete,
    output logic [`PERI_PINS-1:0]   o_uo_out,
    output logic [`PERI_DATA_W-1:0] o_data,
    output logic                    o_data_ready,
    output logic [15:2]             o_user_interrupts
);

    // Slot arrays, indexed by slot number
    wire [`PERI_SLOTS-1:0][`PERI_DATA_W-1:0] user_rdata;
    wire [`PERI_SLOTS-1:0]                   user_ready;
    wire [`PERI_SLOTS-1:0][`PERI_PINS-1:0]   user_pins;
    wire [`PERI_SLOTS-1:0][7:0]              simple_rdata;
    wire [`PERI_SLOTS-1:0][`PERI_PINS-1:0]   simple_pins;

    peri_size_t [`PERI_SLOTS-1:0] user_write_n;
    peri_size_t [`PERI_SLOTS-1:0] user_read_n;
    logic       [`PERI_SLOTS-1:0] simple_write;

    logic irq_word_a;
    logic irq_word_b;

    peri_bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_user_rdata         (user_rdata),
        .i_user_ready         (user_ready),
        .i_simple_rdata       (simple_rdata),
        .o_user_write_n       (user_write_n),
        .o_user_read_n        (user_read_n),
        .o_simple_write       (simple_write),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_addr_lo     (i_addr[5:0]),
        .i_data        (i_data),
        .i_write_n     (user_write_n[`PERI_SLOT_GPIO]),
        .i_read_n      (user_read_n[`PERI_SLOT_GPIO]),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (user_rdata[`PERI_SLOT_GPIO]),
        .o_uo_out      (o_uo_out)
    );

    word_peri u_word_a (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ui_in     (i_ui_in),
        .i_addr_lo   (i_addr[5:0]),
        .i_data      (i_data),
        .i_write_n   (user_write_n[`PERI_SLOT_WORD_A]),
        .i_read_n    (user_read_n[`PERI_SLOT_WORD_A]),
        .o_rdata     (user_rdata[`PERI_SLOT_WORD_A]),
        .o_ready     (user_ready[`PERI_SLOT_WORD_A]),
        .o_pins      (user_pins[`PERI_SLOT_WORD_A]),
        .o_interrupt (irq_word_a)
    );

    word_peri u_word_b (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ui_in     (i_ui_in),
        .i_addr_lo   (i_addr[5:0]),
        .i_data      (i_data),
        .i_write_n   (user_write_n[`PERI_SLOT_WORD_B]),
        .i_read_n    (user_read_n[`PERI_SLOT_WORD_B]),
        .o_rdata     (user_rdata[`PERI_SLOT_WORD_B]),
        .o_ready     (user_ready[`PERI_SLOT_WORD_B]),
        .o_pins      (user_pins[`PERI_SLOT_WORD_B]),
        .o_interrupt (irq_word_b)
    );

    byte_peri u_byte_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ui_in   (i_ui_in),
        .i_addr_lo (i_addr[3:0]),
        .i_write   (simple_write[`PERI_SLOT_BYTE_A]),
        .i_data    (i_data[7:0]),
        .o_rdata   (simple_rdata[`PERI_SLOT_BYTE_A]),
        .o_pins    (simple_pins[`PERI_SLOT_BYTE_A])
    );

    byte_peri u_byte_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ui_in   (i_ui_in),
        .i_addr_lo (i_addr[3:0]),
        .i_write   (simple_write[`PERI_SLOT_BYTE_B]),
        .i_data    (i_data[7:0]),
        .o_rdata   (simple_rdata[`PERI_SLOT_BYTE_B]),
        .o_pins    (simple_pins[`PERI_SLOT_BYTE_B])
    );

    // Tie off the word slots that have no peripheral
    // GPIO reports ready and its pins are substituted inside gpio_ctrl
    for (genvar s = 0; s < `PERI_SLOTS; s++) begin : g_user_tie
        if (s != `PERI_SLOT_WORD_A && s != `PERI_SLOT_WORD_B) begin : g_empty
            assign user_ready[s] = 1'b1;
            assign user_pins[s]  = '0;
            if (s != `PERI_SLOT_GPIO) begin : g_no_data
                assign user_rdata[s] = '0;
            end
        end
    end

    for (genvar s = 0; s < `PERI_SLOTS; s++) begin : g_simple_tie
        if (s != `PERI_SLOT_BYTE_A && s != `PERI_SLOT_BYTE_B) begin : g_empty
            assign simple_rdata[s] = '0;
            assign simple_pins[s]  = '0;
        end
    end

    // Interrupt bits 4 and 5 follow the word slots, the rest are idle
    assign o_user_interrupts = {10'h0, irq_word_b, irq_word_a, 2'b00};

endmodule

// File: tests/tb_peri_fabric.sv
// Peripheral fabric testbench
// Random bus traffic against a shadow model of GPIO, pin routing,
// the word and byte peripherals and the interrupt lines

`timescale 1ns/10ps

`include "peri_consts.svh"

module tb_peri_fabric
    import peri_pkg::*;
;

    localparam int WATCHDOG_NS = 400 * 15 * 10;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [10:0] addr;
    logic [31:0] wdata;
    peri_size_t  write_n;
    peri_size_t  read_n;
    logic        read_complete;
    logic [7:0]  uo_out;
    logic [31:0] rdata;
    logic        data_ready;
    logic [15:2] user_irq;

    // Shadow model of the fabric state
    logic [7:0]  m_gpio_out;
    pin_sel_t    m_sel [8];
    logic [31:0] m_word [2];
    logic        m_irq [2];
    logic [7:0]  m_byte [2];

    int          errors;
    int          timeouts;
    logic [31:0] rng_state;

    peri_fabric_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data               (wdata),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_data               (rdata),
        .o_data_ready         (data_ready),
        .o_user_interrupts    (user_irq)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic peri_size_t rand_size(input logic [1:0] r);
        return peri_size_t'((r == 2'b11) ? 2'b10 : r);
    endfunction

    function automatic logic [10:0] word_addr(input logic [3:0] slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [10:0] byte_addr(input logic [3:0] slot, input logic [3:0] rg);
        return {1'b1, 2'b00, slot, rg};
    endfunction

    // Sized write into a 32 bit data register
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] wr,
                                                input peri_size_t size);
        case (size)
            SIZE_BYTE: return {old[31:8], wr[7:0]};
            SIZE_HALF: return {old[31:16], wr[15:0]};
            default:   return wr;
        endcase
    endfunction

    // Routing of each pin from the bank and slot in its select
    function automatic logic [7:0] expected_pins();
        logic [7:0] p;
        logic       b;
        for (int i = 0; i < 8; i++) begin
            b = 1'b0;
            if (m_sel[i].bank) begin
                if (m_sel[i].slot == 4'(`PERI_SLOT_BYTE_A)) b = m_byte[0][i];
                else if (m_sel[i].slot == 4'(`PERI_SLOT_BYTE_B)) b = m_byte[1][i];
            end else begin
                if (m_sel[i].slot == 4'(`PERI_SLOT_GPIO)) b = m_gpio_out[i];
                else if (m_sel[i].slot == 4'(`PERI_SLOT_WORD_A)) b = m_word[0][i];
                else if (m_sel[i].slot == 4'(`PERI_SLOT_WORD_B)) b = m_word[1][i];
            end
            p[i] = b;
        end
        return p;
    endfunction

    function automatic logic [15:2] expected_irq();
        logic [15:2] v;
        v    = '0;
        v[4] = m_irq[0];
        v[5] = m_irq[1];
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [10:0] a, input logic [31:0] d, input peri_size_t sz);
        next_cycle();
        addr    = a;
        wdata   = d;
        write_n = sz;
        @(negedge clk);
        check_value("ready during write", {31'h0, data_ready}, 32'h1);
        next_cycle();
        write_n = SIZE_NONE;
    endtask

    task automatic bus_read(input logic [10:0] a, output logic [31:0] d);
        logic got;
        got = 1'b0;
        next_cycle();
        addr   = a;
        read_n = SIZE_WORD;
        for (int n = 0; n < 10 && !got; n++) begin
            @(negedge clk);
            if (data_ready) got = 1'b1;
        end
        if (!got) begin
            timeouts++;
            $display("Read of address %h got no ready within 10 cycles at %0t ns", a, $time);
        end
        d = rdata;
        next_cycle();
        read_n        = SIZE_NONE;
        read_complete = 1'b1;
        next_cycle();
        read_complete = 1'b0;
    endtask

    task automatic read_check(input logic [10:0] a, input logic [31:0] exp, input string what);
        logic [31:0] d;
        bus_read(a, d);
        check_value(what, d, exp);
    endtask

    task automatic check_outputs();
        @(negedge clk);
        check_value("pin routing", {24'h0, uo_out}, {24'h0, expected_pins()});
        check_value("interrupts", {18'h0, user_irq}, {18'h0, expected_irq()});
    endtask

    // Watchdog sized for the longest expected run
    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic        idx;
        logic [3:0]  slot;
        logic [5:0]  ofs;
        logic [3:0]  rg;
        logic [2:0]  pin;
        pin_sel_t    sel;
        peri_size_t  sz;

        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        errors        = 0;
        timeouts      = 0;
        rng_state     = 32'h5e5fb298;
        m_gpio_out    = '0;
        m_word[0]     = '0;
        m_word[1]     = '0;
        m_irq[0]      = 1'b0;
        m_irq[1]      = 1'b0;
        m_byte[0]     = '0;
        m_byte[1]     = '0;
        for (int i = 0; i < 8; i++) m_sel[i] = pin_sel_t'(`PERI_SEL_RESET);

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        @(negedge clk);
        check_value("ready after reset", {31'h0, data_ready}, 32'h0);
        check_outputs();
        for (int i = 0; i < 8; i++) begin
            read_check(word_addr(4'(`PERI_SLOT_GPIO), {1'b1, 3'(i), 2'b00}),
                       {27'h0, 5'(`PERI_SEL_RESET)}, $sformatf("reset select %0d", i));
        end

        // GPIO output register and input readback
        for (int k = 0; k < 20; k++) begin
            r     = next_rand();
            ui_in = r[7:0];
            d     = next_rand();
            bus_write(word_addr(4'(`PERI_SLOT_GPIO), `GPIO_OFS_OUT), d, rand_size(r[9:8]));
            m_gpio_out = d[7:0];
            check_outputs();
            read_check(word_addr(4'(`PERI_SLOT_GPIO), `GPIO_OFS_OUT), {24'h0, m_gpio_out},
                       "gpio out");
            read_check(word_addr(4'(`PERI_SLOT_GPIO), `GPIO_OFS_IN), {24'h0, ui_in}, "gpio in");
            read_check(byte_addr(4'(`PERI_SLOT_BYTE_A), 4'h1), {24'h0, ~ui_in},
                       "byte inverted input");
        end

        // Sized writes and interrupt flags of the word peripherals
        for (int k = 0; k < 32; k++) begin
            r    = next_rand();
            idx  = r[0];
            slot = idx ? 4'(`PERI_SLOT_WORD_B) : 4'(`PERI_SLOT_WORD_A);
            sz   = rand_size(r[2:1]);
            d    = next_rand();
            bus_write(word_addr(slot, 6'h00), d, sz);
            m_word[idx] = merge_write(m_word[idx], d, sz);
            m_irq[idx]  = 1'b1;
            check_outputs();
            read_check(word_addr(slot, 6'h00), m_word[idx], "word data");
            if (r[3]) begin
                d = next_rand();
                bus_write(word_addr(slot, 6'h04), d, SIZE_WORD);
                if (d[0]) m_irq[idx] = 1'b0;
                check_outputs();
            end
            read_check(word_addr(slot, 6'h04), {31'h0, m_irq[idx]}, "word irq flag");
        end

        // Pin select routing across banks and slots
        r = next_rand();
        bus_write(byte_addr(4'(`PERI_SLOT_BYTE_A), 4'h0), r, SIZE_BYTE);
        m_byte[0] = r[7:0];
        bus_write(byte_addr(4'(`PERI_SLOT_BYTE_B), 4'h0), {r[7:0], r[31:8]}, SIZE_BYTE);
        m_byte[1] = r[15:8];
        for (int k = 0; k < 30; k++) begin
            r   = next_rand();
            pin = r[2:0];
            case (r[6:4] % 3'd6)
                3'd0: sel = {1'b0, 4'(`PERI_SLOT_GPIO)};
                3'd1: sel = {1'b0, 4'(`PERI_SLOT_WORD_A)};
                3'd2: sel = {1'b0, 4'(`PERI_SLOT_WORD_B)};
                3'd3: sel = {1'b1, 4'(`PERI_SLOT_BYTE_A)};
                3'd4: sel = {1'b1, 4'(`PERI_SLOT_BYTE_B)};
                default: begin
                    slot = r[11:8];
                    if (r[7]) begin
                        if (slot <= 4'd1) slot = 4'hE;
                    end else if (slot == 4'(`PERI_SLOT_GPIO) || slot == 4'(`PERI_SLOT_WORD_A)
                                 || slot == 4'(`PERI_SLOT_WORD_B)) begin
                        slot = 4'hF;
                    end
                    sel = {r[7], slot};
                end
            endcase
            bus_write(word_addr(4'(`PERI_SLOT_GPIO), {1'b1, pin, 2'b00}), {r[31:5], sel},
                      SIZE_WORD);
            m_sel[pin] = sel;
            d = next_rand();
            bus_write(word_addr(4'(`PERI_SLOT_GPIO), `GPIO_OFS_OUT), d, SIZE_WORD);
            m_gpio_out = d[7:0];
            check_outputs();
            read_check(word_addr(4'(`PERI_SLOT_GPIO), {1'b1, pin, 2'b00}), {27'h0, m_sel[pin]},
                       "select readback");
        end

        // Empty slots, undefined offsets and byte register writes
        for (int k = 0; k < 8; k++) begin
            r    = next_rand();
            slot = r[3:0];
            if (slot == 4'(`PERI_SLOT_GPIO) || slot == 4'(`PERI_SLOT_WORD_A)
                || slot == 4'(`PERI_SLOT_WORD_B)) slot = 4'h0;
            read_check(word_addr(slot, {r[7:4], 2'b00}), 32'h0, "empty word slot");
            slot = r[11:8];
            if (slot <= 4'd1) slot = 4'hE;
            read_check(byte_addr(slot, r[15:12]), 32'h0, "empty byte slot");
            ofs = {1'b0, r[18:16], 2'b00};
            if (ofs < 6'h08) ofs = 6'h1C;
            read_check(word_addr(4'(`PERI_SLOT_GPIO), ofs), 32'h0, "gpio undefined offset");
            ofs = {r[22:19], 2'b00};
            if (ofs < 6'h08) ofs = 6'h3C;
            read_check(word_addr(r[23] ? 4'(`PERI_SLOT_WORD_B) : 4'(`PERI_SLOT_WORD_A), ofs),
                       32'h0, "word undefined offset");
            rg = r[27:24];
            if (rg <= 4'd1) rg = 4'hF;
            read_check(byte_addr(4'(`PERI_SLOT_BYTE_A), rg), 32'h0, "byte undefined register");
            idx = r[28];
            d   = next_rand();
            bus_write(byte_addr(idx ? 4'(`PERI_SLOT_BYTE_B) : 4'(`PERI_SLOT_BYTE_A), 4'h0), d,
                      rand_size(r[30:29]));
            m_byte[idx] = d[7:0];
            check_outputs();
            read_check(byte_addr(idx ? 4'(`PERI_SLOT_BYTE_B) : 4'(`PERI_SLOT_BYTE_A), 4'h0),
                       {24'h0, m_byte[idx]}, "byte register");
        end

        $display("Errors: %0d mismatches, %0d read timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: peri_fabric.f
+incdir+hw
hw/peri_pkg.sv
hw/byte_peri.sv
hw/word_peri.sv
hw/gpio_ctrl.sv
hw/peri_bus_ctrl.sv
hw/peri_fabric_top.sv
tests/tb_peri_fabric.sv

// File: Makefile
# Verilator build and run for the peripheral fabric testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_peri_fabric
FILELIST  ?= peri_fabric.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
